// File: Makefile
# Verilator build and run for the exchange memory testbench

VERILATOR ?= verilator
TOP       ?= xmem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** PASSED ***

SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_EXE) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/array_bank.sv
//--------------------------------------------------------------------------
// single port word bank, CPU first, accelerator when the CPU is idle.
// word address = bank start of the partition + byte offset / 4.
// accesses that land at or beyond BANK_DEPTH are dropped
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module array_bank #(
    parameter int BANK_DEPTH = 1024
) (
    input  logic                      clk,
    input  logic                      rstn,

    input  xmem_req_pkg::bank_req_t   cpu_req,
    input  xmem_req_pkg::acc_req_t    acc_req,
    input  xmem_map_pkg::bank_start_t bank_start,

    output logic                      arg_ack,
    output xmem_req_pkg::bank_rsp_t   bank_rsp
);
    import xmem_map_pkg::*;
    import xmem_req_pkg::*;

    logic [3:0][7:0]    mem [BANK_DEPTH];

    bank_req_t          acc_bank;
    bank_req_t          sel;
    owner_e             owner;
    logic [BANK_AW-1:0] word_adr;
    logic               adr_ok;
    logic               do_acc;
    logic               do_rd;

    logic               rd_vld;
    owner_e             owner_q;
    logic [DW-1:0]      data_q;

    //------------------------------------------------------------------------
    // arbitration
    //------------------------------------------------------------------------
    // accelerator works on whole words
    always_comb begin
        acc_bank.valid = acc_req.valid;
        acc_bank.we    = {4{acc_req.we}};
        acc_bank.re    = !acc_req.we;
        acc_bank.part  = acc_req.part;
        acc_bank.wofs  = acc_req.ofs[OFS_W-1:2];
        acc_bank.wdat  = acc_req.wdat;
    end

    assign arg_ack = acc_req.valid && !cpu_req.valid;

    always_comb begin
        if (cpu_req.valid) begin
            sel   = cpu_req;
            owner = OWN_CPU;
        end else begin
            sel   = acc_bank;
            owner = OWN_ACC;
        end
    end

    assign word_adr = bank_start[sel.part] + BANK_AW'(sel.wofs);
    assign adr_ok   = int'(word_adr) < BANK_DEPTH;
    assign do_acc   = sel.valid && adr_ok;
    assign do_rd    = do_acc && sel.re;

    //------------------------------------------------------------------------
    // storage
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_acc) begin
            for (int b = 0; b < 4; b++) begin
                if (sel.we[b]) begin
                    mem[word_adr][b] <= sel.wdat[8*b +: 8];
                end
            end
        end
    end

    // read data is the word before any same cycle write
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= do_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            owner_q <= owner;
            data_q  <= mem[word_adr];
        end
    end

    always_comb begin
        bank_rsp.valid = rd_vld;
        bank_rsp.owner = owner_q;
        bank_rsp.data  = data_q;
    end

endmodule

// File: logic/read_return.sv
//--------------------------------------------------------------------------
// steers bank read results to the CPU or accelerator outputs.
// data outputs hold their last word between valid pulses
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module read_return (
    input  logic                        clk,
    input  logic                        rstn,

    input  xmem_req_pkg::bank_rsp_t     bank_rsp,

    output logic [xmem_map_pkg::DW-1:0] risc_do,
    output logic                        risc_do_vld,
    output logic [xmem_map_pkg::DW-1:0] rdat,
    output logic                        rdat_vld
);
    import xmem_req_pkg::*;

    logic to_cpu;
    logic to_acc;

    assign to_cpu = bank_rsp.valid && (bank_rsp.owner == OWN_CPU);
    assign to_acc = bank_rsp.valid && (bank_rsp.owner == OWN_ACC);

    // one cycle pulse per response
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            risc_do_vld <= 1'b0;
            rdat_vld    <= 1'b0;
        end else begin
            risc_do_vld <= to_cpu;
            rdat_vld    <= to_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (to_cpu) begin
            risc_do <= bank_rsp.data;
        end
        if (to_acc) begin
            rdat <= bank_rsp.data;
        end
    end

endmodule

// File: logic/risc_cmd_decode.sv
//--------------------------------------------------------------------------
// CPU strobes are sampled every edge, the CPU port is always ready.
// a memory access hits when offset/4 < bank size of its partition.
// sizes reset to zero, so every access misses until configured
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module risc_cmd_decode #(
    parameter int NUM_PART = 4
) (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic [3:0]                  risc_we,
    input  logic                        risc_re,
    input  xmem_map_pkg::risc_adr_u     risc_adr,
    input  logic [xmem_map_pkg::DW-1:0] risc_di,

    output xmem_req_pkg::bank_req_t     cpu_req,
    output xmem_map_pkg::bank_start_t   bank_start
);
    import xmem_map_pkg::*;
    import xmem_req_pkg::*;

    // size of every partition, zero for partitions not built
    logic [MAX_PART-1:0][SIZE_W-1:0] part_size;

    logic              cfg_sel;
    logic              cfg_we;
    logic              mem_acc;
    logic              hit;
    logic [WOFS_W-1:0] wofs;

    bank_req_t         req_d;
    bank_req_t         req_q;
    logic              req_vld;

    //------------------------------------------------------------------------
    // configuration space
    //------------------------------------------------------------------------
    assign cfg_sel = risc_adr.raw[CFG_BIT];
    assign cfg_we  = cfg_sel && risc_we[0];

    for (genvar p = 0; p < MAX_PART; p++) begin : g_part
        if (p < NUM_PART) begin : g_cfg
            logic [BANK_AW-1:0] base;
            logic [SIZE_W-1:0]  size;
            logic               sel;

            assign sel = cfg_we && (risc_adr.cfg.part == PART_W'(p));

            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    base <= '0;
                    size <= '0;
                end else if (sel) begin
                    // range start writes are accepted and dropped
                    case (risc_adr.cfg.cmd)
                        CMD_BANK_START: base <= risc_di[BANK_AW-1:0];
                        CMD_BANK_SIZE:  size <= risc_di[SIZE_W-1:0];
                        default: ;
                    endcase
                end
            end

            assign bank_start[p] = base;
            assign part_size[p]  = size;
        end else begin : g_none
            // unbuilt partition, size zero means it never hits
            assign bank_start[p] = '0;
            assign part_size[p]  = '0;
        end
    end

    //------------------------------------------------------------------------
    // memory space filter
    //------------------------------------------------------------------------
    assign mem_acc = !cfg_sel && (risc_re || (risc_we != 4'b0000));
    assign wofs    = risc_adr.mem.ofs[OFS_W-1:2];
    assign hit     = mem_acc && ({1'b0, wofs} < part_size[risc_adr.mem.part]);

    always_comb begin
        req_d.valid = hit;
        req_d.we    = risc_we;
        req_d.re    = risc_re;
        req_d.part  = risc_adr.mem.part;
        req_d.wofs  = wofs;
        req_d.wdat  = risc_di;
    end

    // one valid cycle per hit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_vld <= 1'b0;
        end else begin
            req_vld <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            req_q <= req_d;
        end
    end

    always_comb begin
        cpu_req       = req_q;
        cpu_req.valid = req_vld;
    end

endmodule

// File: logic/xmem_map_pkg.sv
//--------------------------------------------------------------------------
// CPU address map of the exchange memory, at most four partitions.
// bit 15 selects configuration space, config commands are word aligned
// and the two byte lane bits of a config address are ignored
//--------------------------------------------------------------------------
package xmem_map_pkg;

    localparam int DW      = 32;
    localparam int ADR_W   = 16;
    localparam int PART_W  = 2;
    localparam int OFS_W   = 12;
    localparam int BANK_AW = 10;
    localparam int CFG_BIT = 15;

    // derived widths
    localparam int MAX_PART = 1 << PART_W;
    localparam int WOFS_W   = OFS_W - 2;
    localparam int SIZE_W   = BANK_AW + 1;
    localparam int CMD_W    = 4;

    typedef enum logic [CMD_W-1:0] {
        CMD_RANGE_START = 4'h0,
        CMD_BANK_START  = 4'h1,
        CMD_BANK_SIZE   = 4'h2
    } cmd_e;

    // config space: cfg | rsvd | part | cmd | byte lane
    typedef struct packed {
        logic                          cfg;
        logic [ADR_W-PART_W-CMD_W-4:0] rsvd;
        logic [PART_W-1:0]             part;
        cmd_e                          cmd;
        logic [1:0]                    lane;
    } cfg_view_t;

    // memory space: cfg | rsvd | part | byte offset
    typedef struct packed {
        logic                          cfg;
        logic [ADR_W-PART_W-OFS_W-2:0] rsvd;
        logic [PART_W-1:0]             part;
        logic [OFS_W-1:0]              ofs;
    } mem_view_t;

    typedef union packed {
        logic [ADR_W-1:0] raw;
        cfg_view_t        cfg;
        mem_view_t        mem;
    } risc_adr_u;

    // start word of every partition inside the bank
    typedef logic [MAX_PART-1:0][BANK_AW-1:0] bank_start_t;

endpackage

// File: logic/xmem_req_pkg.sv
//--------------------------------------------------------------------------
// request and response words passed between decoder, bank and return
// stage. accelerator offsets are byte offsets, bank offsets are words
//--------------------------------------------------------------------------
package xmem_req_pkg;

    import xmem_map_pkg::*;

    typedef enum logic {
        OWN_CPU = 1'b0,
        OWN_ACC = 1'b1
    } owner_e;

    // one access to the single port bank
    typedef struct packed {
        logic              valid;
        logic [3:0]        we;
        logic              re;
        logic [PART_W-1:0] part;
        logic [WOFS_W-1:0] wofs;
        logic [DW-1:0]     wdat;
    } bank_req_t;

    // accelerator side, whole words only
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [PART_W-1:0] part;
        logic [OFS_W-1:0]  ofs;
        logic [DW-1:0]     wdat;
    } acc_req_t;

    // registered read result with its requester
    typedef struct packed {
        logic          valid;
        owner_e        owner;
        logic [DW-1:0] data;
    } bank_rsp_t;

endpackage

// File: logic/xmem_top.sv
//--------------------------------------------------------------------------
// exchange memory with one CPU port and one accelerator port on a single
// port bank. CPU has priority, the accelerator waits with arg_ack low.
// NUM_PART must not exceed four
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xmem_top #(
    parameter int NUM_PART   = 4,
    parameter int BANK_DEPTH = 1024
) (
    input  logic                        clk,
    input  logic                        rstn,

    // CPU port
    input  logic [3:0]                  risc_we,
    input  logic                        risc_re,
    input  xmem_map_pkg::risc_adr_u     risc_adr,
    input  logic [xmem_map_pkg::DW-1:0] risc_di,
    output logic [xmem_map_pkg::DW-1:0] risc_do,
    output logic                        risc_do_vld,

    // accelerator port
    input  xmem_req_pkg::acc_req_t      acc_req,
    output logic                        arg_ack,
    output logic [xmem_map_pkg::DW-1:0] rdat,
    output logic                        rdat_vld
);
    import xmem_map_pkg::*;
    import xmem_req_pkg::*;

    bank_req_t   cpu_req;
    bank_start_t bank_start;
    bank_rsp_t   bank_rsp;

    risc_cmd_decode #(
        .NUM_PART   ( NUM_PART   )
    ) inst_risc_cmd_decode (
        .clk        ( clk        ),
        .rstn       ( rstn       ),
        .risc_we    ( risc_we    ),
        .risc_re    ( risc_re    ),
        .risc_adr   ( risc_adr   ),
        .risc_di    ( risc_di    ),
        .cpu_req    ( cpu_req    ),
        .bank_start ( bank_start )
    );

    array_bank #(
        .BANK_DEPTH ( BANK_DEPTH )
    ) inst_array_bank (
        .clk        ( clk        ),
        .rstn       ( rstn       ),
        .cpu_req    ( cpu_req    ),
        .acc_req    ( acc_req    ),
        .bank_start ( bank_start ),
        .arg_ack    ( arg_ack    ),
        .bank_rsp   ( bank_rsp   )
    );

    read_return inst_read_return (
        .clk         ( clk         ),
        .rstn        ( rstn        ),
        .bank_rsp    ( bank_rsp    ),
        .risc_do     ( risc_do     ),
        .risc_do_vld ( risc_do_vld ),
        .rdat        ( rdat        ),
        .rdat_vld    ( rdat_vld    )
    );

endmodule

// File: sim.f
logic/xmem_map_pkg.sv
logic/xmem_req_pkg.sv
logic/risc_cmd_decode.sv
logic/array_bank.sv
logic/read_return.sv
logic/xmem_top.sv
tests/xmem_sva.sv
tests/xmem_tb.sv

// File: tests/xmem_sva.sv
//--------------------------------------------------------------------------
// timing checks bound into xmem_top. assumes all four partitions are
// built and the accelerator is only used after one has been configured
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xmem_sva (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [3:0]                  risc_we,
    input  logic                        risc_re,
    input  xmem_map_pkg::risc_adr_u     risc_adr,
    input  logic [xmem_map_pkg::DW-1:0] risc_di,
    input  xmem_req_pkg::bank_req_t     cpu_req,
    input  xmem_req_pkg::acc_req_t      acc_req,
    input  logic                        arg_ack,
    input  logic                        risc_do_vld,
    input  logic                        rdat_vld
);
    import xmem_map_pkg::*;
    import xmem_req_pkg::*;

    int unsigned sva_errors = 0;
    logic        size_seen;
    logic        cfg_wr;
    logic        mem_acc;
    logic        mem_hit;
    int          size_q [MAX_PART];

    // CPU hit as seen at the port, from the sizes the CPU wrote
    assign cfg_wr  = risc_we[0] && risc_adr.raw[CFG_BIT];
    assign mem_acc = !risc_adr.raw[CFG_BIT] && (risc_re || risc_we != 4'b0000);
    assign mem_hit = mem_acc && (int'(risc_adr.mem.ofs) / 4 < size_q[risc_adr.mem.part]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            size_seen <= 1'b0;
            for (int p = 0; p < MAX_PART; p++) begin
                size_q[p] <= 0;
            end
        end else if (cfg_wr && risc_adr.cfg.cmd == CMD_BANK_SIZE) begin
            size_seen                 <= 1'b1;
            size_q[risc_adr.cfg.part] <= int'(risc_di[SIZE_W-1:0]);
        end
    end

    //------------------------------------------------------------------------
    // properties
    //------------------------------------------------------------------------
    a_quiet_until_cfg : assert property (@(posedge clk) disable iff (!rstn)
        !size_seen |-> !cpu_req.valid && !risc_do_vld && !rdat_vld)
        else begin
            $error("read activity before any bank size was set");
            sva_errors++;
        end

    a_cpu_latency : assert property (@(posedge clk) disable iff (!rstn)
        mem_hit && risc_re |-> ##3 risc_do_vld)
        else begin
            $error("CPU read data not valid 3 cycles after the read");
            sva_errors++;
        end

    a_cpu_no_extra : assert property (@(posedge clk) disable iff (!rstn)
        risc_do_vld |-> $past(mem_hit && risc_re, 3))
        else begin
            $error("risc_do_vld without a matching CPU read");
            sva_errors++;
        end

    a_ack_after_hit : assert property (@(posedge clk) disable iff (!rstn)
        mem_hit |=> !arg_ack)
        else begin
            $error("arg_ack high in the cycle after a CPU hit");
            sva_errors++;
        end

    a_ack_when_free : assert property (@(posedge clk) disable iff (!rstn)
        acc_req.valid && !$past(mem_hit) |-> arg_ack)
        else begin
            $error("accelerator request not acknowledged while the bank was free");
            sva_errors++;
        end

    a_acc_latency : assert property (@(posedge clk) disable iff (!rstn)
        arg_ack && !acc_req.we |-> ##2 rdat_vld)
        else begin
            $error("accelerator read data late or missing");
            sva_errors++;
        end

    a_acc_no_extra : assert property (@(posedge clk) disable iff (!rstn)
        rdat_vld |-> $past(arg_ack && !acc_req.we, 2))
        else begin
            $error("rdat_vld without a matching accelerator read");
            sva_errors++;
        end

endmodule

bind xmem_top xmem_sva i_sva (
    .clk         ( clk         ),
    .rstn        ( rstn        ),
    .risc_we     ( risc_we     ),
    .risc_re     ( risc_re     ),
    .risc_adr    ( risc_adr    ),
    .risc_di     ( risc_di     ),
    .cpu_req     ( cpu_req     ),
    .acc_req     ( acc_req     ),
    .arg_ack     ( arg_ack     ),
    .risc_do_vld ( risc_do_vld ),
    .rdat_vld    ( rdat_vld    )
);

// File: tests/xmem_tb.sv
//--------------------------------------------------------------------------
// directed and random tests against a model of partition map and bank.
// accelerator offsets stay inside their partition, partitions never overlap
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xmem_tb;
    import xmem_map_pkg::*;
    import xmem_req_pkg::*;

    localparam int PERIOD  = 100;
    localparam int DRV_DLY = 10;
    localparam int ACK_MAX = 64;
    localparam int TEST_CYCLES = 4 + 12 + 220 + 30 + 30 + 50 + 60 + 10;
    localparam int MARGIN  = 200;

    logic          clk;
    logic          rstn;
    logic [3:0]    risc_we;
    logic          risc_re;
    risc_adr_u     risc_adr;
    logic [DW-1:0] risc_di;
    logic [DW-1:0] risc_do;
    logic          risc_do_vld;
    acc_req_t      acc_req;
    logic          arg_ack;
    logic [DW-1:0] rdat;
    logic          rdat_vld;

    // reference model
    logic [DW-1:0]      model_mem [1 << BANK_AW];
    logic [BANK_AW-1:0] model_start [MAX_PART];
    int                 model_size [MAX_PART];
    logic [DW-1:0]      cpu_exp [$];
    logic [DW-1:0]      acc_exp [$];
    int                 errors = 0;
    int                 checks = 0;
    int                 test_no = 0;

    xmem_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(PERIOD * (TEST_CYCLES + MARGIN));
        $display("watchdog expired after %0d cycles, the run did not finish",
                 TEST_CYCLES + MARGIN);
        $display("*** FAILED ***");
        $finish;
    end

    //------------------------------------------------------------------------
    // stimulus
    //------------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    function automatic int word_of(int part, int ofs);
        return (int'(model_start[part]) + ofs / 4) % (1 << BANK_AW);
    endfunction

    task automatic cpu_cfg(int part, cmd_e cmd, int value);
        next_cycle();
        risc_we      = 4'hf;
        risc_re      = 1'b0;
        risc_adr.raw = {1'b1, 7'd0, PART_W'(part), cmd, 2'b00};
        risc_di      = value;
        if (cmd == CMD_BANK_START) model_start[part] = BANK_AW'(value);
        if (cmd == CMD_BANK_SIZE) model_size[part] = value;
    endtask

    task automatic cpu_write(int part, int ofs, logic [3:0] mask, logic [DW-1:0] data);
        int w;
        next_cycle();
        risc_we      = mask;
        risc_re      = 1'b0;
        risc_adr.raw = {2'b00, PART_W'(part), OFS_W'(ofs)};
        risc_di      = data;
        if (ofs / 4 < model_size[part]) begin
            w = word_of(part, ofs);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) model_mem[w][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic cpu_read(int part, int ofs);
        next_cycle();
        risc_we      = 4'h0;
        risc_re      = 1'b1;
        risc_adr.raw = {2'b00, PART_W'(part), OFS_W'(ofs)};
        if (ofs / 4 < model_size[part]) cpu_exp.push_back(model_mem[word_of(part, ofs)]);
    endtask

    task automatic cpu_idle();
        next_cycle();
        risc_we = 4'h0;
        risc_re = 1'b0;
    endtask

    // request is held until arg_ack, sampled mid cycle
    task automatic wait_ack(output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!arg_ack && n < ACK_MAX) begin
            n++;
            @(negedge clk);
        end
        ok = arg_ack;
        if (!ok) begin
            $display("accelerator request was never acknowledged, time %0t ns", $time);
            errors++;
        end
    endtask

    task automatic acc_access(bit we, int part, int ofs, logic [DW-1:0] data);
        bit ok;
        next_cycle();
        acc_req = '{valid: 1'b1, we: we, part: PART_W'(part), ofs: OFS_W'(ofs), wdat: data};
        wait_ack(ok);
        if (ok && we) model_mem[word_of(part, ofs)] = data;
        if (ok && !we) acc_exp.push_back(model_mem[word_of(part, ofs)]);
    endtask

    task automatic acc_idle();
        next_cycle();
        acc_req = '0;
    endtask

    task automatic report_test(string name);
        test_no++;
        $display("test %0d %s done, errors so far %0d", test_no, name, errors);
    endtask

    //------------------------------------------------------------------------
    // result checks, outputs are stable at the falling edge
    //------------------------------------------------------------------------
    task automatic check_result(logic [DW-1:0] got, bit cpu_side);
        logic [DW-1:0] want;
        checks++;
        assert (cpu_side ? cpu_exp.size() > 0 : acc_exp.size() > 0) else begin
            $display("read result arrived that nobody asked for, time %0t ns", $time);
            errors++;
        end
        if (cpu_side ? cpu_exp.size() > 0 : acc_exp.size() > 0) begin
            want = cpu_side ? cpu_exp.pop_front() : acc_exp.pop_front();
            assert (got === want) else begin
                $display("[FAIL] %0t ns: %s read returned %h, model has %h", $time,
                         cpu_side ? "CPU" : "accelerator", got, want);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn && risc_do_vld) check_result(risc_do, 1'b1);
        if (rstn && rdat_vld) check_result(rdat, 1'b0);
    end

    //------------------------------------------------------------------------
    // test sequence
    //------------------------------------------------------------------------
    initial begin
        int p;
        int n;
        void'($urandom(32'hb277cf27));
        rstn = 1'b0;
        risc_we = 4'h0;
        risc_re = 1'b0;
        risc_adr.raw = '0;
        risc_di = '0;
        acc_req = '0;
        for (int i = 0; i < MAX_PART; i++) begin
            model_start[i] = '0;
            model_size[i] = 0;
        end
        repeat (4) @(posedge clk);
        #DRV_DLY rstn = 1'b1;

        for (int i = 0; i < 8; i++) cpu_read(i % MAX_PART, 4 * i);
        cpu_idle();
        repeat (4) next_cycle();
        report_test("reads before configuration");

        // partitions 256 words apart so they never overlap
        // range start goes last and must leave start and size alone
        for (int i = 0; i < 3; i++) begin
            cpu_cfg(i, CMD_BANK_START, i * 256 + int'($urandom_range(0, 63)));
            cpu_cfg(i, CMD_BANK_SIZE, int'($urandom_range(8, 23)));
            cpu_cfg(i, CMD_RANGE_START, i * 4096);
            for (int w = 0; w < model_size[i]; w++) cpu_write(i, 4 * w, 4'hf, $urandom);
        end
        for (int i = 0; i < 120; i++) begin
            p = int'($urandom_range(0, 2));
            n = 4 * int'($urandom_range(0, model_size[p] - 1));
            if ($urandom_range(0, 1) == 1) cpu_write(p, n, 4'hf, $urandom);
            else cpu_read(p, n);
        end
        report_test("random CPU words");

        for (int i = 0; i < 12; i++) begin
            p = int'($urandom_range(0, 2));
            n = 4 * int'($urandom_range(0, model_size[p] - 1));
            cpu_write(p, n, 4'($urandom_range(1, 14)), $urandom);
            cpu_read(p, n);
        end
        report_test("byte enables");

        // shrink by one word so a dropped write would land on live data
        for (int i = 0; i < 3; i++) begin
            n = model_size[i];
            cpu_read(i, 4 * n);
            cpu_read(i, 4 * (n + int'($urandom_range(1, 40))));
            cpu_cfg(i, CMD_BANK_SIZE, n - 1);
            cpu_write(i, 4 * (n - 1), 4'hf, $urandom);
            cpu_cfg(i, CMD_BANK_SIZE, n);
            cpu_read(i, 4 * (n - 1));
            cpu_read(i, 0);
        end
        cpu_read(3, 0);
        report_test("out of range accesses");

        // accelerator waits behind a stream of CPU hits
        fork
            begin
                for (int i = 0; i < 8; i++) acc_access(1'b1, 1, 4 * i, $urandom);
                acc_idle();
            end
            begin
                for (int i = 0; i < 8; i++) cpu_read(0, 4 * (i % model_size[0]));
                cpu_idle();
            end
        join
        for (int i = 0; i < 8; i++) cpu_read(1, 4 * i);
        cpu_idle();
        report_test("accelerator writes");

        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    acc_access(1'b0, 2, 4 * int'($urandom_range(0, model_size[2] - 1)), '0);
                end
                acc_idle();
            end
            for (int i = 0; i < 12; i++) begin
                cpu_read(0, 4 * int'($urandom_range(0, model_size[0] - 1)));
                cpu_idle();
            end
        join
        repeat (6) next_cycle();
        assert (cpu_exp.size() == 0 && acc_exp.size() == 0) else begin
            $display("%0d CPU and %0d accelerator read results never arrived",
                     cpu_exp.size(), acc_exp.size());
            errors++;
        end
        report_test("interleaved reads");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_no, checks, errors, i_dut.i_sva.sva_errors);
        if (errors == 0 && i_dut.i_sva.sva_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
